// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := regfile_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed!

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# pass or fail is taken from the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
verilog/regfile_pkg.sv
verilog/regfile_storage.sv
verilog/regfile_debug_apb.sv
verilog/regfile_top.sv
verification/regfile_tb.sv

// File: verification/regfile_tb.sv
`timescale 1ns/100ps

module regfile_tb
    import regfile_pkg::*;
;

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 4;

    typedef enum logic [2:0] {
        OP_CORE_WR,
        OP_DUAL_WR,
        OP_APB_WR,
        OP_APB_RD,
        OP_APB_WR_CONFLICT,
        OP_READ_CHECK
    } op_t;

    logic      clk;
    logic      rst_n;
    reg_idx_t  wb0_idx_i;
    reg_data_t wb0_data_i;
    reg_idx_t  wb1_idx_i;
    reg_data_t wb1_data_i;
    reg_idx_t  rs0a_idx_i;
    reg_idx_t  rs0b_idx_i;
    reg_idx_t  rs1a_idx_i;
    reg_idx_t  rs1b_idx_i;
    reg_data_t rs0a_data_o;
    reg_data_t rs0b_data_o;
    reg_data_t rs1a_data_o;
    reg_data_t rs1b_data_o;
    logic      psel_i;
    logic      penable_i;
    logic      pwrite_i;
    dbg_addr_t paddr_i;
    reg_data_t pwdata_i;
    reg_data_t prdata_o;
    logic      pready_o;
    logic      pslverr_o;

    // expected architectural state, x0 stays zero
    reg_data_t ref_regs [0:REG_COUNT-1];

    // stimulus table, one field per queue
    op_t       op_q [$];
    reg_idx_t  idx0_q [$];
    reg_idx_t  idx1_q [$];
    dbg_addr_t addr_q [$];
    reg_data_t data0_q [$];
    reg_data_t data1_q [$];
    string     name_q [$];

    logic [31:0] rng_state = 32'h1bf4;
    logic        table_ready = 1'b0;
    int          pass_count = 0;
    int          fail_count = 0;

    regfile_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb0_idx_i   (wb0_idx_i),
        .wb0_data_i  (wb0_data_i),
        .wb1_idx_i   (wb1_idx_i),
        .wb1_data_i  (wb1_data_i),
        .rs0a_idx_i  (rs0a_idx_i),
        .rs0a_data_o (rs0a_data_o),
        .rs0b_idx_i  (rs0b_idx_i),
        .rs0b_data_o (rs0b_data_o),
        .rs1a_idx_i  (rs1a_idx_i),
        .rs1a_data_o (rs1a_data_o),
        .rs1b_idx_i  (rs1b_idx_i),
        .rs1b_data_o (rs1b_data_o),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o)
    );

    always #HALF_PERIOD clk = ~clk;

    //------------------------------------------------------------------------
    // helpers
    //------------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_random(output reg_data_t value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    task automatic check_data(input string name, input reg_data_t expected,
                              input reg_data_t actual);
        if (actual === expected) begin
            pass_count++;
            $display("PASS %s: 0x%08h", name, actual);
        end else begin
            fail_count++;
            $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual === expected) begin
            pass_count++;
            $display("PASS %s: %b", name, actual);
        end else begin
            fail_count++;
            $display("FAIL %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // stall cycles seen on one APB transfer
    task automatic check_count(input string name, input int expected, input int actual);
        if (actual == expected) begin
            pass_count++;
            $display("PASS %s: %0d", name, actual);
        end else begin
            fail_count++;
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic add_entry(input op_t op, input reg_idx_t i0, input reg_idx_t i1,
                             input dbg_addr_t addr, input reg_data_t d0,
                             input reg_data_t d1, input string name);
        op_q.push_back(op);
        idx0_q.push_back(i0);
        idx1_q.push_back(i1);
        addr_q.push_back(addr);
        data0_q.push_back(d0);
        data1_q.push_back(d1);
        name_q.push_back(name);
    endtask

    // read ports are combinational, sampled 1 ns after the indices change
    task automatic check_read_ports(input string name, input reg_idx_t a, input reg_idx_t b,
                                    input reg_idx_t c, input reg_idx_t d);
        rs0a_idx_i = a;
        rs0b_idx_i = b;
        rs1a_idx_i = c;
        rs1b_idx_i = d;
        #1;
        check_data({name, " rs0a"}, ref_regs[a], rs0a_data_o);
        check_data({name, " rs0b"}, ref_regs[b], rs0b_data_o);
        check_data({name, " rs1a"}, ref_regs[c], rs1a_data_o);
        check_data({name, " rs1b"}, ref_regs[d], rs1b_data_o);
    endtask

    // one cycle of write-back on both ports, then idle
    task automatic core_write(input reg_idx_t i0, input reg_data_t d0,
                              input reg_idx_t i1, input reg_data_t d1);
        @(negedge clk);
        wb0_idx_i  = i0;
        wb0_data_i = d0;
        wb1_idx_i  = i1;
        wb1_data_i = d1;
        @(negedge clk);
        wb0_idx_i = '0;
        wb1_idx_i = '0;
        if (i1 != reg_idx_t'(ZERO_REG)) begin
            ref_regs[i1] = d1;
        end
        if (i0 != reg_idx_t'(ZERO_REG)) begin
            ref_regs[i0] = d0;
        end
    endtask

    // setup, then access cycles until pready
    // with collide set, wb0 hits the same register in the first access cycle
    task automatic apb_transfer(input logic write, input dbg_addr_t addr,
                                input reg_data_t wdata, input logic collide,
                                input reg_data_t core_data, output reg_data_t rdata,
                                output logic slverr, output int waits);
        logic done;
        done   = 1'b0;
        waits  = 0;
        rdata  = '0;
        slverr = 1'b0;
        @(negedge clk);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk);
        penable_i = 1'b1;
        if (collide) begin
            wb0_idx_i  = addr[DBG_ADDR_W-1:DBG_IDX_LSB];
            wb0_data_i = core_data;
        end
        while (!done) begin
            @(negedge clk);
            if (pready_o === 1'b1) begin
                done   = 1'b1;
                rdata  = prdata_o;
                slverr = pslverr_o;
            end else begin
                waits++;
                wb0_idx_i = '0;
            end
        end
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        wb0_idx_i = '0;
    endtask

    //------------------------------------------------------------------------
    // stimulus table
    //------------------------------------------------------------------------

    task automatic build_table();
        reg_data_t r0;
        reg_data_t r1;
        draw_random(r0);
        draw_random(r1);
        add_entry(OP_READ_CHECK, r0[4:0], r1[4:0], '0, '0, '0, "after reset a");
        draw_random(r0);
        draw_random(r1);
        add_entry(OP_READ_CHECK, r0[4:0], r1[4:0], '0, '0, '0, "after reset b");
        draw_random(r0);
        add_entry(OP_CORE_WR, 5'd5, 5'd0, '0, r0, '0, "wb0 write x5");
        draw_random(r0);
        draw_random(r1);
        add_entry(OP_DUAL_WR, 5'd7, 5'd9, '0, r0, r1, "dual write x7 x9");
        draw_random(r1);
        add_entry(OP_DUAL_WR, 5'd0, 5'd10, '0, 32'hdead_beef, r1, "wb0 index zero");
        add_entry(OP_CORE_WR, 5'd0, 5'd0, '0, 32'hffff_ffff, '0, "write x0 ignored");
        draw_random(r0);
        draw_random(r1);
        add_entry(OP_DUAL_WR, 5'd12, 5'd12, '0, r0, r1, "same target wb0 wins");
        draw_random(r0);
        add_entry(OP_APB_WR, '0, '0, {5'd14, 2'b00}, r0, '0, "apb write x14");
        add_entry(OP_APB_RD, '0, '0, {5'd14, 2'b00}, '0, '0, "apb read x14");
        add_entry(OP_APB_RD, '0, '0, {5'd5, 2'b00}, '0, '0, "apb read core x5");
        draw_random(r0);
        draw_random(r1);
        add_entry(OP_APB_WR_CONFLICT, '0, '0, {5'd16, 2'b00}, r0, r1, "apb conflict x16");
        add_entry(OP_APB_RD, '0, '0, {5'd16, 2'b00}, '0, '0, "apb read x16");
        draw_random(r0);
        add_entry(OP_APB_WR, '0, '0, {5'd14, 2'b01}, r0, '0, "apb misaligned write");
        add_entry(OP_APB_RD, '0, '0, {5'd5, 2'b10}, '0, '0, "apb misaligned read");
        add_entry(OP_APB_WR, '0, '0, {5'd0, 2'b00}, 32'h1234_5678, '0, "apb write x0");
        for (int k = 0; k < 3; k++) begin
            draw_random(r0);
            draw_random(r1);
            add_entry(OP_READ_CHECK, r0[4:0], r1[4:0], '0, '0, '0, "final sweep");
        end
    endtask

    task automatic apply_entry(input int n);
        reg_idx_t  apb_idx;
        logic      misaligned;
        reg_data_t rdata;
        reg_data_t r0;
        reg_data_t r1;
        logic      slverr;
        int        waits;
        apb_idx    = addr_q[n][DBG_ADDR_W-1:DBG_IDX_LSB];
        misaligned = (addr_q[n][DBG_IDX_LSB-1:0] != 2'b00);
        case (op_q[n])
            OP_CORE_WR: begin
                core_write(idx0_q[n], data0_q[n], '0, '0);
                check_read_ports(name_q[n], idx0_q[n], idx0_q[n], idx0_q[n], idx0_q[n]);
            end
            OP_DUAL_WR: begin
                core_write(idx0_q[n], data0_q[n], idx1_q[n], data1_q[n]);
                check_read_ports(name_q[n], idx0_q[n], idx1_q[n], idx1_q[n], idx0_q[n]);
            end
            OP_APB_WR, OP_APB_WR_CONFLICT: begin
                apb_transfer(1'b1, addr_q[n], data0_q[n], op_q[n] == OP_APB_WR_CONFLICT,
                             data1_q[n], rdata, slverr, waits);
                // core write lands first, the debug write one edge later
                if (op_q[n] == OP_APB_WR_CONFLICT && apb_idx != reg_idx_t'(ZERO_REG)) begin
                    ref_regs[apb_idx] = data1_q[n];
                end
                if (!misaligned && apb_idx != reg_idx_t'(ZERO_REG)) begin
                    ref_regs[apb_idx] = data0_q[n];
                end
                check_flag({name_q[n], " pslverr"}, misaligned, slverr);
                check_count({name_q[n], " stall cycles"},
                            (op_q[n] == OP_APB_WR_CONFLICT) ? 1 : 0, waits);
                check_read_ports(name_q[n], apb_idx, apb_idx, apb_idx, apb_idx);
            end
            OP_APB_RD: begin
                apb_transfer(1'b0, addr_q[n], '0, 1'b0, '0, rdata, slverr, waits);
                check_flag({name_q[n], " pslverr"}, misaligned, slverr);
                check_count({name_q[n], " stall cycles"}, 0, waits);
                if (!misaligned) begin
                    check_data({name_q[n], " prdata"}, ref_regs[apb_idx], rdata);
                end
                check_read_ports(name_q[n], apb_idx, apb_idx, apb_idx, apb_idx);
            end
            default: begin
                @(negedge clk);
                draw_random(r0);
                draw_random(r1);
                check_read_ports(name_q[n], idx0_q[n], idx1_q[n], r0[4:0], r1[4:0]);
                check_flag({name_q[n], " pready idle"}, 1'b0, pready_o);
                check_flag({name_q[n], " pslverr idle"}, 1'b0, pslverr_o);
            end
        endcase
    endtask

    //------------------------------------------------------------------------
    // main sequence and watchdog
    //------------------------------------------------------------------------

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        wb0_idx_i  = '0;
        wb0_data_i = '0;
        wb1_idx_i  = '0;
        wb1_data_i = '0;
        rs0a_idx_i = '0;
        rs0b_idx_i = '0;
        rs1a_idx_i = '0;
        rs1b_idx_i = '0;
        psel_i     = 1'b0;
        penable_i  = 1'b0;
        pwrite_i   = 1'b0;
        paddr_i    = '0;
        pwdata_i   = '0;
        for (int i = 0; i < REG_COUNT; i++) begin
            ref_regs[i] = '0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int n = 0; n < op_q.size(); n++) begin
            apply_entry(n);
        end
        @(negedge clk);
        $display("checks: %0d, passed: %0d, failed: %0d",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // budget of 10 cycles per table entry plus reset
    initial begin
        int limit;
        wait (table_ready);
        limit = op_q.size() * 10 + RESET_CYCLES;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: verilog/regfile_debug_apb.sv
`timescale 1ns/100ps

module regfile_debug_apb
    import regfile_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // APB3 slave
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  dbg_addr_t paddr_i,
    input  reg_data_t pwdata_i,
    output reg_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,

    // core write-back indices, for conflict detection only
    input  reg_idx_t  wb0_idx_i,
    input  reg_idx_t  wb1_idx_i,

    // storage side
    input  reg_data_t dbg_rdata_i,
    output logic      dbg_we_o,
    output reg_idx_t  dbg_widx_o,
    output reg_data_t dbg_wdata_o,
    output reg_idx_t  dbg_ridx_o
);

    //------------------------------------------------------------------------
    // address decode
    //------------------------------------------------------------------------

    reg_idx_t  reg_idx;
    logic      misaligned;
    logic      setup_phase;
    logic      access_phase;
    logic      core_conflict;
    reg_data_t rdata_q;

    assign reg_idx    = paddr_i[DBG_ADDR_W-1:DBG_IDX_LSB];
    assign misaligned = |paddr_i[DBG_IDX_LSB-1:0];

    assign setup_phase  = psel_i && !penable_i;
    assign access_phase = psel_i && penable_i;

    // a zero index on a write-back port is no write, so never a conflict
    assign core_conflict =
        ((wb0_idx_i != reg_idx_t'(ZERO_REG)) && (wb0_idx_i == reg_idx)) ||
        ((wb1_idx_i != reg_idx_t'(ZERO_REG)) && (wb1_idx_i == reg_idx));

    //------------------------------------------------------------------------
    // handshake
    //------------------------------------------------------------------------

    // writes wait while a core port targets the same register
    // reads and bad addresses finish in the first access cycle
    assign pready_o  = access_phase && (misaligned || !pwrite_i || !core_conflict);
    assign pslverr_o = access_phase && misaligned;

    // x0 writes complete on the bus but touch nothing
    assign dbg_we_o = access_phase && pwrite_i && !misaligned && !core_conflict &&
                      (reg_idx != reg_idx_t'(ZERO_REG));

    assign dbg_widx_o  = reg_idx;
    assign dbg_wdata_o = pwdata_i;
    assign dbg_ridx_o  = reg_idx;

    //------------------------------------------------------------------------
    // read data stage
    //------------------------------------------------------------------------

    // loads at the end of setup, presented while pready is high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (setup_phase && !pwrite_i) begin
            rdata_q <= dbg_rdata_i;
        end
    end

    assign prdata_o = rdata_q;

    //------------------------------------------------------------------------
    // assertions
    //------------------------------------------------------------------------

    // master keeps the transfer unchanged across stalled access cycles
    a_apb_stable_in_wait : assert property (
        @(posedge clk) disable iff (!rst_n)
        (access_phase && !pready_o) |=>
            (psel_i && penable_i && $stable(pwrite_i) &&
             $stable(paddr_i) && $stable(pwdata_i))
    ) else $error("APB inputs changed during a stalled access cycle");

endmodule

// File: verilog/regfile_pkg.sv
package regfile_pkg;

    //------------------------------------------------------------------------
    // register file geometry
    //------------------------------------------------------------------------

    // width of one architectural register
    localparam int XLEN = 32;

    // x0..x31, x0 is hardwired to zero
    localparam int REG_COUNT = 32;

    // bits needed to name one register
    localparam int REG_IDX_W = 5;

    // index of the zero register, also "no write" on a write-back port
    localparam int ZERO_REG = 0;

    //------------------------------------------------------------------------
    // debug address layout
    //------------------------------------------------------------------------

    // word addressed APB window, one word per register
    localparam int DBG_ADDR_W = 7;

    // lowest address bit of the register index
    // bits below it are byte offset and must be zero
    localparam int DBG_IDX_LSB = 2;

    //------------------------------------------------------------------------
    // vector types
    //------------------------------------------------------------------------

    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [XLEN-1:0]       reg_data_t;
    typedef logic [DBG_ADDR_W-1:0] dbg_addr_t;

endpackage

// File: verilog/regfile_storage.sv
`timescale 1ns/100ps

module regfile_storage
    import regfile_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // port 0 write-back has priority over port 1
    input  reg_idx_t  wb0_idx_i,
    input  reg_data_t wb0_data_i,
    input  reg_idx_t  wb1_idx_i,
    input  reg_data_t wb1_data_i,

    // debug write from the APB slave
    input  logic      dbg_we_i,
    input  reg_idx_t  dbg_widx_i,
    input  reg_data_t dbg_wdata_i,

    // operand reads, two per issue slot
    input  reg_idx_t  rs0a_idx_i,
    input  reg_idx_t  rs0b_idx_i,
    input  reg_idx_t  rs1a_idx_i,
    input  reg_idx_t  rs1b_idx_i,

    // debug read
    input  reg_idx_t  dbg_ridx_i,

    output reg_data_t rs0a_data_o,
    output reg_data_t rs0b_data_o,
    output reg_data_t rs1a_data_o,
    output reg_data_t rs1b_data_o,
    output reg_data_t dbg_rdata_o
);

    //------------------------------------------------------------------------
    // register array
    //------------------------------------------------------------------------

    // storage for x1..x31 only
    reg_data_t regs_q [1:REG_COUNT-1];

    // each register takes wb0 before wb1 before debug
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            for (int i = 1; i < REG_COUNT; i++) begin
                if (wb0_idx_i == reg_idx_t'(i)) begin
                    regs_q[i] <= wb0_data_i;
                end else if (wb1_idx_i == reg_idx_t'(i)) begin
                    regs_q[i] <= wb1_data_i;
                end else if (dbg_we_i && (dbg_widx_i == reg_idx_t'(i))) begin
                    regs_q[i] <= dbg_wdata_i;
                end
            end
        end
    end

    //------------------------------------------------------------------------
    // read multiplexers
    //------------------------------------------------------------------------

    // x0 reads as zero on every port
    function automatic reg_data_t read_reg(input reg_idx_t idx);
        reg_data_t value;
        value = '0;
        if (idx != reg_idx_t'(ZERO_REG)) begin
            value = regs_q[idx];
        end
        return value;
    endfunction

    // four operand muxes and the debug mux
    always_comb begin
        rs0a_data_o = read_reg(rs0a_idx_i);
        rs0b_data_o = read_reg(rs0b_idx_i);
        rs1a_data_o = read_reg(rs1a_idx_i);
        rs1b_data_o = read_reg(rs1b_idx_i);
        dbg_rdata_o = read_reg(dbg_ridx_i);
    end

    //------------------------------------------------------------------------
    // assertions
    //------------------------------------------------------------------------

    // the APB slave stalls instead of racing a core write
    a_dbg_no_core_collision : assert property (
        @(posedge clk) disable iff (!rst_n)
        dbg_we_i |-> ((dbg_widx_i != wb0_idx_i) && (dbg_widx_i != wb1_idx_i))
    ) else $error("debug write collides with core write to x%0d", dbg_widx_i);

    // the slave drops writes to x0 before they get here
    a_dbg_widx_nonzero : assert property (
        @(posedge clk) disable iff (!rst_n)
        dbg_we_i |-> (dbg_widx_i != reg_idx_t'(ZERO_REG))
    ) else $error("debug write enable with zero register index");

endmodule

// File: verilog/regfile_top.sv
`timescale 1ns/100ps

module regfile_top
    import regfile_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // write-back ports
    input  reg_idx_t  wb0_idx_i,
    input  reg_data_t wb0_data_i,
    input  reg_idx_t  wb1_idx_i,
    input  reg_data_t wb1_data_i,

    // operand read ports
    input  reg_idx_t  rs0a_idx_i,
    output reg_data_t rs0a_data_o,
    input  reg_idx_t  rs0b_idx_i,
    output reg_data_t rs0b_data_o,
    input  reg_idx_t  rs1a_idx_i,
    output reg_data_t rs1a_data_o,
    input  reg_idx_t  rs1b_idx_i,
    output reg_data_t rs1b_data_o,

    // APB debug port
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  dbg_addr_t paddr_i,
    input  reg_data_t pwdata_i,
    output reg_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    // debug path between slave and storage
    logic      dbg_we;
    reg_idx_t  dbg_widx;
    reg_data_t dbg_wdata;
    reg_idx_t  dbg_ridx;
    reg_data_t dbg_rdata;

    regfile_storage u_storage (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb0_idx_i   (wb0_idx_i),
        .wb0_data_i  (wb0_data_i),
        .wb1_idx_i   (wb1_idx_i),
        .wb1_data_i  (wb1_data_i),
        .dbg_we_i    (dbg_we),
        .dbg_widx_i  (dbg_widx),
        .dbg_wdata_i (dbg_wdata),
        .rs0a_idx_i  (rs0a_idx_i),
        .rs0b_idx_i  (rs0b_idx_i),
        .rs1a_idx_i  (rs1a_idx_i),
        .rs1b_idx_i  (rs1b_idx_i),
        .dbg_ridx_i  (dbg_ridx),
        .rs0a_data_o (rs0a_data_o),
        .rs0b_data_o (rs0b_data_o),
        .rs1a_data_o (rs1a_data_o),
        .rs1b_data_o (rs1b_data_o),
        .dbg_rdata_o (dbg_rdata)
    );

    regfile_debug_apb u_debug_apb (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .wb0_idx_i   (wb0_idx_i),
        .wb1_idx_i   (wb1_idx_i),
        .dbg_rdata_i (dbg_rdata),
        .dbg_we_o    (dbg_we),
        .dbg_widx_o  (dbg_widx),
        .dbg_wdata_o (dbg_wdata),
        .dbg_ridx_o  (dbg_ridx)
    );

endmodule
